//--- hw/mont_settings.svh
`ifndef MONT_SETTINGS_SVH
`define MONT_SETTINGS_SVH

// operand width W, must be even
// 1024 works as well, only the simulation gets longer
`define MONT_WIDTH 64

// accumulator holds up to 8m before the shift
// so W+4 bits leave one spare bit for the sign of the final compare
`define MONT_ACC_WIDTH (`MONT_WIDTH + 4)

// one radix-4 digit of a per iteration
`define MONT_DIGITS (`MONT_WIDTH / 2)

`endif

//--- hw/mont_pkg.sv
`include "mont_settings.svh"

package mont_pkg;

    // plain W-bit operand (a, b, m and the result)
    typedef logic [`MONT_WIDTH-1:0] operand_t;

    // running sum C of the montgomery loop
    typedef logic [`MONT_ACC_WIDTH-1:0] acc_t;

    // sequencer states, two cycles per digit
    typedef enum logic [2:0] {
        ST_IDLE,     // waiting for start
        ST_LOAD,     // capture operands, form multiples
        ST_ADD_B,    // C += digit(a) * b
        ST_REDUCE,   // C = (C + q*m) / 4
        ST_SUBTRACT, // final compare against m
        ST_DONE      // done pulse
    } mont_state_e;

    // which precomputed multiple goes into the adder
    typedef enum logic [1:0] {
        SEL_ZERO,
        SEL_X1,
        SEL_X2,
        SEL_X3
    } mult_sel_e;

    // datapath opcode from the sequencer
    typedef enum logic [1:0] {
        OP_HOLD,  // accumulator keeps its value
        OP_LOAD,  // take multiples, clear acc
        OP_ADD_B, // add selected b multiple
        OP_ADD_M  // add selected m multiple, shift by two
    } exec_op_e;

    // the three inputs of one multiplication
    typedef struct packed {
        operand_t a;
        operand_t b;
        operand_t m;
    } operands_t;

    // command word decode -> execute
    typedef struct packed {
        exec_op_e  op;
        mult_sel_e sel;
    } exec_cmd_t;

endpackage

//--- hw/mont_decode.sv
`include "mont_settings.svh"

module mont_decode import mont_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  logic       start,
    input  operands_t  operands,
    input  logic [1:0] acc_low,  // two low bits of C after the b add
    output exec_cmd_t  exec_cmd,
    output logic       finish
);

    // counter wide enough for W/2 digits, also for tiny W
    localparam int CNT_W = $clog2(`MONT_DIGITS + 1);
    localparam logic [CNT_W-1:0] LAST_DIGIT = CNT_W'(`MONT_DIGITS - 1);

    mont_state_e      state;
    mont_state_e      state_next;
    logic [CNT_W-1:0] digit_cnt;   // digits of a already consumed
    logic             last_digit;
    operand_t         a_shift;     // a, two bits gone per iteration
    logic [1:0]       m_low;       // m mod 4, fixed for the whole run
    mult_sel_e        q_sel;       // quotient digit for the reduce step

    assign last_digit = (digit_cnt == LAST_DIGIT);

    // sequencer
    // start edge -> LOAD -> W/2 x (ADD_B, REDUCE) -> SUBTRACT -> DONE
    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (start) begin  // start only looked at here
                    state_next = ST_LOAD;
                end
            end
            ST_LOAD:     state_next = ST_ADD_B;
            ST_ADD_B:    state_next = ST_REDUCE;
            ST_REDUCE:   state_next = last_digit ? ST_SUBTRACT : ST_ADD_B;
            ST_SUBTRACT: state_next = ST_DONE;
            ST_DONE:     state_next = ST_IDLE;
            default:     state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // iteration counter, one step per finished reduce
    always_ff @(posedge clk) begin
        if (!resetn) begin
            digit_cnt <= '0;
        end else if (state == ST_LOAD) begin
            digit_cnt <= '0;
        end else if (state == ST_REDUCE) begin
            digit_cnt <= digit_cnt + 1'b1;
        end
    end

    // multiplier digits
    // low two bits of a_shift always hold the current digit
    always_ff @(posedge clk) begin
        if (state == ST_LOAD) begin
            a_shift <= operands.a;
            m_low   <= operands.m[1:0];
        end else if (state == ST_REDUCE) begin
            a_shift <= a_shift >> 2;  // next digit moves down
        end
    end

    // quotient digit
    // need acc + q*m = 0 mod 4, and m is its own inverse mod 4
    //   m = 1 mod 4 -> q = -acc
    //   m = 3 mod 4 -> q = acc
    always_comb begin
        case (m_low)
            2'b01:   q_sel = mult_sel_e'(-acc_low);
            2'b11:   q_sel = mult_sel_e'(acc_low);
            default: q_sel = SEL_ZERO;  // even m, outside the valid range
        endcase
    end

    // command word, decoded straight from the state
    always_comb begin
        exec_cmd = '{op: OP_HOLD, sel: SEL_ZERO};
        case (state)
            ST_LOAD: begin
                exec_cmd.op = OP_LOAD;
            end
            ST_ADD_B: begin
                exec_cmd.op  = OP_ADD_B;
                exec_cmd.sel = mult_sel_e'(a_shift[1:0]);  // digit of a picks b multiple
            end
            ST_REDUCE: begin
                exec_cmd.op  = OP_ADD_M;
                exec_cmd.sel = q_sel;
            end
            default: begin
                exec_cmd.op = OP_HOLD;
            end
        endcase
    end

    // acc is final during SUBTRACT, result stage takes it on this edge
    assign finish = (state == ST_SUBTRACT);

    // no encoding outside the six states, also not X after reset
    a_state_legal: assert property (
        @(posedge clk) disable iff (!resetn)
        state inside {ST_IDLE, ST_LOAD, ST_ADD_B, ST_REDUCE, ST_SUBTRACT, ST_DONE}
    ) else $error("mont_decode: illegal state %0d", state);

    // load and hold must not drive a stray multiple into the datapath
    a_sel_idle: assert property (
        @(posedge clk) disable iff (!resetn)
        (exec_cmd.op inside {OP_HOLD, OP_LOAD}) |-> (exec_cmd.sel == SEL_ZERO)
    ) else $error("mont_decode: sel %0d with op %0d", exec_cmd.sel, exec_cmd.op);

endmodule

//--- hw/mont_execute.sv
`include "mont_settings.svh"

module mont_execute import mont_pkg::*; (
    input  logic      clk,
    input  logic      resetn,
    input  operands_t operands,
    input  exec_cmd_t exec_cmd,
    output acc_t      acc
);

    // 3x of a W-bit value needs two extra bits
    localparam int MW = `MONT_WIDTH + 2;

    typedef logic [MW-1:0] mult_t;

    mult_t b_ext;  // operands widened to multiple width
    mult_t m_ext;
    mult_t b_x1;   // precomputed multiples of b
    mult_t b_x2;
    mult_t b_x3;
    mult_t m_x1;   // precomputed multiples of m
    mult_t m_x2;
    mult_t m_x3;
    mult_t b_pick; // multiple chosen by exec_cmd.sel
    mult_t m_pick;
    acc_t  sum_b;  // C + digit*b
    acc_t  sum_m;  // C + q*m, low bits zero when q is right

    // 0/1x/2x/3x selection, shared by the b and m sides
    function automatic mult_t pick_multiple(
        input mult_sel_e sel,
        input mult_t     x1,
        input mult_t     x2,
        input mult_t     x3
    );
        mult_t pick;
        case (sel)
            SEL_X1:  pick = x1;
            SEL_X2:  pick = x2;
            SEL_X3:  pick = x3;
            default: pick = '0;
        endcase
        return pick;
    endfunction

    assign b_ext = {2'b00, operands.b};
    assign m_ext = {2'b00, operands.m};

    // multiples formed once, in the load cycle
    always_ff @(posedge clk) begin
        if (exec_cmd.op == OP_LOAD) begin
            b_x1 <= b_ext;
            b_x2 <= b_ext << 1;
            b_x3 <= b_ext + (b_ext << 1);
            m_x1 <= m_ext;
            m_x2 <= m_ext << 1;
            m_x3 <= m_ext + (m_ext << 1);
        end
    end

    assign b_pick = pick_multiple(exec_cmd.sel, b_x1, b_x2, b_x3);
    assign m_pick = pick_multiple(exec_cmd.sel, m_x1, m_x2, m_x3);

    // single-cycle adders, C < 2m so the sums stay below 8m
    assign sum_b = acc + {2'b00, b_pick};
    assign sum_m = acc + {2'b00, m_pick};

    // accumulator
    always_ff @(posedge clk) begin
        if (!resetn) begin
            acc <= '0;
        end else begin
            case (exec_cmd.op)
                OP_LOAD:  acc <= '0;          // fresh run
                OP_ADD_B: acc <= sum_b;
                OP_ADD_M: acc <= sum_m >> 2;  // exact divide by 4
                default:  acc <= acc;         // hold
            endcase
        end
    end

    // decode picks q from acc_low and m mod 4
    // a wrong pick would drop set bits in the shift
    a_reduce_exact: assert property (
        @(posedge clk) disable iff (!resetn)
        (exec_cmd.op == OP_ADD_M) |-> (sum_m[1:0] == 2'b00)
    ) else $error("mont_execute: reduce sum low bits %b, q=%0d", sum_m[1:0], exec_cmd.sel);

endmodule

//--- hw/mont_result.sv
`include "mont_settings.svh"

module mont_result import mont_pkg::*; (
    input  logic      clk,
    input  logic      resetn,
    input  logic      finish,    // one cycle, acc final
    input  operands_t operands,
    input  acc_t      acc,
    output operand_t  result,
    output logic      done
);

    acc_t diff;   // acc - m, top bit is the sign
    logic acc_lt_m;

    // C < 2m at this point, so one subtraction is enough
    assign diff     = acc - {4'b0000, operands.m};
    assign acc_lt_m = diff[`MONT_ACC_WIDTH-1];  // borrow -> acc below m

    always_ff @(posedge clk) begin
        if (!resetn) begin
            result <= '0;
            done   <= 1'b0;
        end else begin
            done <= finish;  // high during ST_DONE
            if (finish) begin
                result <= acc_lt_m ? acc[`MONT_WIDTH-1:0] : diff[`MONT_WIDTH-1:0];
            end
            // result held otherwise, until the next finish
        end
    end

    // done is a strobe, never a level
    a_done_pulse: assert property (
        @(posedge clk) disable iff (!resetn)
        done |=> !done
    ) else $error("mont_result: done high two cycles");

    // loop bound C < 2m plus the subtract must give a reduced value
    a_result_reduced: assert property (
        @(posedge clk) disable iff (!resetn)
        finish |=> (result < $past(operands.m))
    ) else $error("mont_result: result %h not below m", result);

endmodule

//--- hw/montgomery_top.sv
// radix-4 montgomery multiplier, result = a*b*2^-W mod m
// m odd, a and b below m, operands held stable for the whole run
// counting the start edge as the first, done rises on edge W+3
module montgomery_top import mont_pkg::*; (
    input  logic      clk,
    input  logic      resetn,
    input  logic      start,     // one cycle, ignored while busy
    input  operands_t operands,
    output operand_t  result,
    output logic      done       // one cycle pulse
);

    exec_cmd_t  exec_cmd;  // decode -> execute
    acc_t       acc;       // execute -> result
    logic [1:0] acc_low;   // execute -> decode, for the quotient digit
    logic       finish;    // decode -> result

    assign acc_low = acc[1:0];

    mont_decode u_decode (
        .clk      (clk),
        .resetn   (resetn),
        .start    (start),
        .operands (operands),
        .acc_low  (acc_low),
        .exec_cmd (exec_cmd),
        .finish   (finish)
    );

    mont_execute u_execute (
        .clk      (clk),
        .resetn   (resetn),
        .operands (operands),
        .exec_cmd (exec_cmd),
        .acc      (acc)
    );

    mont_result u_result (
        .clk      (clk),
        .resetn   (resetn),
        .finish   (finish),
        .operands (operands),  // only m is used there
        .acc      (acc),
        .result   (result),
        .done     (done)
    );

endmodule

//--- verification/tb_mont_model.svh
`ifndef TB_MONT_MODEL_SVH
`define TB_MONT_MODEL_SVH

// golden model and random source for tb_montgomery
// included inside the testbench module, so mont_pkg types are visible

// one step of a 32-bit fibonacci lfsr
// taps 32, 22, 2, 1 (x^32 + x^22 + x^2 + x + 1)
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};  // new bit enters at the bottom
endfunction

// bit-serial radix-2 montgomery, one bit of a per step
// gives a*b*2^-W mod m for odd m and a, b below m
function automatic operand_t mont_model(
    input operand_t a,
    input operand_t b,
    input operand_t m
);
    // c stays below 2m, plus b and m it needs two spare bits
    logic [`MONT_WIDTH+1:0] c;
    c = '0;
    for (int i = 0; i < `MONT_WIDTH; i++) begin
        if (a[i]) begin
            c = c + b;
        end
        if (c[0]) begin
            c = c + m;  // make c even, m odd
        end
        c = c >> 1;     // exact halving
    end
    // c < 2m here, one subtraction reduces it
    if (c >= {2'b00, m}) begin
        c = c - m;
    end
    return c[`MONT_WIDTH-1:0];
endfunction

`endif

//--- verification/tb_montgomery.sv
`include "mont_settings.svh"

module tb_montgomery import mont_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    `include "tb_mont_model.svh"

    localparam int W            = `MONT_WIDTH;
    localparam int NUM_DIRECTED = 5;
    localparam int NUM_RANDOM   = 20;
    localparam int NUM_VECS     = NUM_DIRECTED + NUM_RANDOM;
    localparam int LATENCY      = W + 3;       // start edge counted as the first
    localparam int DONE_TIMEOUT = 4 * W + 50;  // edges before giving up on done
    localparam logic [31:0] LFSR_SEED = 32'h7eb6_4323;

    // one row of the stimulus table
    typedef struct packed {
        operands_t ops;
        operand_t  expected;
    } vec_t;

    logic      clk;
    logic      resetn;
    logic      start;
    operands_t operands;
    operand_t  result;
    logic      done;

    vec_t        vectors [NUM_VECS];
    logic [31:0] lfsr_state;
    operand_t    last_result;  // value result must hold between runs

    montgomery_top dut (
        .clk      (clk),
        .resetn   (resetn),
        .start    (start),
        .operands (operands),
        .result   (result),
        .done     (done)
    );

    always #20 clk = ~clk;  // 40 ns period

    // W fresh lfsr bits with one step per bit
    function automatic operand_t random_operand();
        operand_t r;
        for (int i = 0; i < W; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r[i] = lfsr_state[0];
        end
        return r;
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1, "testbench stopped at first error");
    endtask

    task automatic check_value(input string name, input operand_t got, input operand_t exp);
        assert (got == exp) else begin
            fail_run($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_int(input string name, input int got, input int exp);
        assert (got == exp) else begin
            fail_run($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
        end
    endtask

    // directed rows then lfsr rows then expected values from the model
    task automatic build_table();
        operand_t top_bit;
        operand_t m;
        top_bit        = '0;
        top_bit[W-1]   = 1'b1;
        m              = {(W/2){2'b10}} | operand_t'(1);  // odd with top bit set
        vectors[0].ops = '{a: '0, b: {(W/2){2'b01}}, m: m};  // a = 0
        vectors[1].ops = '{a: operand_t'(1), b: operand_t'(1), m: m};
        vectors[2].ops = '{a: m - 1, b: m - 1, m: m};         // largest operands
        vectors[3].ops = '{a: operand_t'(2), b: operand_t'(2), m: operand_t'(3)};
        vectors[4].ops = '{a: {(W/2){2'b01}}, b: '1 - 2, m: '1};  // all-ones m
        for (int i = NUM_DIRECTED; i < NUM_VECS; i++) begin
            vectors[i].ops.m = random_operand() | top_bit | operand_t'(1);
            vectors[i].ops.a = random_operand() & ~top_bit;  // below m
            vectors[i].ops.b = random_operand() & ~top_bit;
        end
        for (int i = 0; i < NUM_VECS; i++) begin
            vectors[i].expected = mont_model(vectors[i].ops.a, vectors[i].ops.b,
                                             vectors[i].ops.m);
        end
    endtask

    // one multiplication started on a falling edge
    // restart_edge places an extra start with other a and b
    task automatic run_op(input vec_t v, input int restart_edge);
        int edges;
        edges    = 0;
        @(negedge clk);
        operands = v.ops;
        start    = 1'b1;
        forever begin
            @(posedge clk);
            edges++;             // edge 1 samples start
            @(negedge clk);
            start = (edges == restart_edge);  // DUT busy so this pulse is ignored
            if (start) begin
                operands.a = ~v.ops.a;  // second operands must not be taken
                operands.b = ~v.ops.b;
            end
            if (done) begin
                break;
            end
            check_value("result (held)", result, last_result);
            assert (edges <= DONE_TIMEOUT) else begin
                fail_run("timeout: done never came after start");
            end
        end
        check_int("done latency", edges, LATENCY);
        check_value("result", result, v.expected);
        last_result = v.expected;
        @(posedge clk);
        @(negedge clk);
        check_int("done (second cycle)", done, 0);  // strobe lasts one cycle
    endtask

    // idle gap where operands wiggle and result must not follow
    task automatic idle_check(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            operands = ~operands;
            check_int("done (idle)", done, 0);
            check_value("result (idle)", result, last_result);
        end
    endtask

    // reset lands halfway through a run
    task automatic reset_mid_op(input vec_t v);
        @(negedge clk);
        operands = v.ops;
        start    = 1'b1;
        for (int i = 0; i < W / 2; i++) begin
            @(negedge clk);
            start = 1'b0;
            check_int("done (before reset)", done, 0);
        end
        resetn = 1'b0;
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            check_int("done (in reset)", done, 0);
            check_value("result (in reset)", result, '0);
        end
        resetn      = 1'b1;
        last_result = '0;   // reset clears the result register
        idle_check(3);
    endtask

    initial begin
        clk         = 1'b0;
        resetn      = 1'b0;
        start       = 1'b0;
        operands    = '0;
        last_result = '0;
        lfsr_state  = LFSR_SEED;
        build_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        idle_check(2);

        // every table row with latency and hold checks
        for (int i = 0; i < NUM_VECS; i++) begin
            run_op(vectors[i], 0);
            idle_check(2 + i % 3);
        end

        // extra start pulses while busy
        run_op(vectors[2], W / 2);
        run_op(vectors[NUM_DIRECTED], 2);
        idle_check(2);

        // reset in the middle then a clean run
        reset_mid_op(vectors[NUM_DIRECTED + 1]);
        run_op(vectors[4], 0);
        idle_check(4);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- project.f
+incdir+hw
+incdir+verification
hw/mont_pkg.sv
hw/mont_decode.sv
hw/mont_execute.sv
hw/mont_result.sv
hw/montgomery_top.sv
verification/tb_montgomery.sv

//--- Bender.yml
package:
  name: montgomery

sources:
  - include_dirs:
      - hw
    files:
      - hw/mont_pkg.sv
      - hw/mont_decode.sv
      - hw/mont_execute.sv
      - hw/mont_result.sv
      - hw/montgomery_top.sv
  - target: test
    include_dirs:
      - hw
      - verification
    files:
      - verification/tb_montgomery.sv
